// File: hdl/cpu_consts.svh
// constants shared by the fetch, decode and register blocks
// queue depth must be a power of two and hold at least two bus words
// reset pc must be word aligned, the fetch master only issues word reads
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// first instruction fetch address
`define CPU_RESET_PC    32'h0000_0000

// opcode queue depth in bytes
`define CPU_QUEUE_BYTES 8

// lowest register code of the bank, E0 to FF
`define CPU_REG_BASE    8'he0

// opcode field values
`define CPU_OP_NOP      8'h00
`define CPU_OP_LD_IMM   8'h03
`define CPU_ZZZ_BYTE    3'd2
`define CPU_ZZZ_LONG    3'd4

`endif

// File: hdl/cpu_pkg.sv
// types shared by the cpu front end
// size_t encodes how many register bytes a move writes
`default_nettype none

package cpu_pkg;

    typedef logic [7:0]  byte_t;      // instruction or register byte
    typedef logic [31:0] word_t;      // bus data, register value
    typedef logic [31:0] addr_t;      // instruction byte address
    typedef logic [31:0] opwin_t;     // four queued bytes, lowest first
    typedef logic [7:0]  regcode_t;   // E0..FF select the bank
    typedef logic [1:0]  fetch_cnt_t; // bytes consumed per cycle
    typedef logic [1:0]  size_t;      // register write size

    // write sizes carried on regs_we
    localparam size_t SZ_NONE = 2'd0;
    localparam size_t SZ_BYTE = 2'd1;
    localparam size_t SZ_WORD = 2'd2;
    localparam size_t SZ_LONG = 2'd3;

    // controller phases
    typedef enum logic [1:0] {
        FETCH,    // first opcode byte
        EXEC,     // byte after a register prefix
        FILL_IMM  // upper immediate bytes
    } phase_t;

    typedef enum logic {
        ALU_NOP,
        ALU_MOVE
    } alu_op_t;

endpackage

`default_nettype wire

// File: hdl/exec_if.sv
// decoded operation from the controller to the register bank
// an operation is valid while alu_op is ALU_MOVE and alu_wait is low
`timescale 1ns/1ns
`default_nettype none

interface exec_if import cpu_pkg::*; ();

    alu_op_t  alu_op;
    word_t    alu_imm;
    logic     alu_smux;  // 1 takes alu_imm, 0 the source register
    logic     alu_wait;  // immediate still being collected
    regcode_t regs_src;
    regcode_t regs_dst;
    size_t    regs_we;

    modport ctrl (
        output alu_op, alu_imm, alu_smux, alu_wait,
        output regs_src, regs_dst, regs_we
    );

    modport exec (
        input alu_op, alu_imm, alu_smux, alu_wait,
        input regs_src, regs_dst, regs_we
    );

endinterface

`default_nettype wire

// File: hdl/fetch_queue.sv
// Wishbone classic instruction fetch with a circular byte queue
// reads are word aligned with all byte lanes, one read at a time
// a read starts only while four bytes are free, so a returned word always fits
// op bytes are undefined while op_ok is low
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module fetch_queue import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      wb_dat_i,
    input  logic       wb_ack,
    input  fetch_cnt_t fetched,
    output logic       wb_cyc,
    output logic       wb_stb,
    output addr_t      wb_adr,
    output logic [3:0] wb_sel,
    output opwin_t     op,
    output logic       op_ok
);

    localparam int PW = $clog2(`CPU_QUEUE_BYTES);

    typedef logic [PW-1:0] qptr_t;
    typedef logic [PW:0]   qcnt_t;

    byte_t qmem [`CPU_QUEUE_BYTES];
    qptr_t rd_ptr;
    qptr_t wr_ptr;
    qcnt_t count;
    logic  push;
    logic  room;

    assign wb_sel = 4'hf;
    assign push   = wb_stb && wb_ack;
    assign room   = count <= qcnt_t'(`CPU_QUEUE_BYTES - 4); // pops only add room
    assign op_ok  = count >= qcnt_t'(4);

    // bus master, cyc drops for one cycle after every ack
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_adr <= addr_t'(`CPU_RESET_PC);
        end else if (wb_cyc) begin
            if (wb_ack) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
                wb_adr <= wb_adr + 32'd4;
            end
        end else if (room) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
        end
    end

    // returned word goes in little endian
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < 4; i++) begin
                qmem[wr_ptr + qptr_t'(i)] <= wb_dat_i[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + qptr_t'(4);
            end
            rd_ptr <= rd_ptr + qptr_t'(fetched);
            count  <= count + (push ? qcnt_t'(4) : qcnt_t'(0)) - qcnt_t'(fetched);
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            op[8*i +: 8] = qmem[rd_ptr + qptr_t'(i)]; // window wraps around the queue
        end
    end

    // controller may only consume bytes that are queued
    a_pop_in_fill: assert property (@(posedge clk) disable iff (rst)
        qcnt_t'(fetched) <= count);

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb |-> wb_cyc);

endmodule

`default_nettype wire

// File: hdl/decode_ctrl.sv
// multi-phase decoder for NOP, LD R,# and the register prefixed loads
// opcodes outside that set are skipped as one-byte NOPs
// after any byte is consumed the decoder idles one cycle for the window
// a prefix with zz=3 is not a register operation and is skipped too
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module decode_ctrl import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  opwin_t     op,
    input  logic       op_ok,
    output fetch_cnt_t fetched,
    exec_if.ctrl       ex
);

    phase_t     op_phase;
    phase_t     nx_phase;
    logic [1:0] op_zz;     // operand size from the first byte
    logic [1:0] nx_op_zz;
    logic       ram_wait;
    regcode_t   nx_src;
    regcode_t   nx_dst;
    word_t      nx_alu_imm;
    alu_op_t    nx_alu_op;
    logic       nx_alu_smux;
    logic       nx_alu_wait;
    size_t      nx_regs_we;

    // short register field to bank code
    function automatic regcode_t expand_reg(input logic [2:0] r, input logic [1:0] zz);
        if (zz == 2'd0) begin
            return `CPU_REG_BASE + regcode_t'({r[2:1], 1'b0, ~r[0]}); // W,A,B,C.. pairs
        end
        return `CPU_REG_BASE + regcode_t'({r, 2'b00});
    endfunction

    function automatic size_t zz_size(input logic [1:0] zz);
        case (zz)
            2'd0:    return SZ_BYTE;
            2'd1:    return SZ_WORD;
            default: return SZ_LONG;
        endcase
    endfunction

    always_comb begin
        fetched     = '0;
        nx_phase    = op_phase;
        nx_op_zz    = op_zz;
        nx_src      = ex.regs_src;
        nx_dst      = ex.regs_dst;
        nx_alu_imm  = ex.alu_imm;
        nx_alu_smux = ex.alu_smux;
        nx_alu_wait = ex.alu_wait;
        nx_alu_op   = ex.alu_wait ? ex.alu_op : ALU_NOP;   // one cycle unless held
        nx_regs_we  = ex.alu_wait ? ex.regs_we : SZ_NONE;
        if (op_ok && !ram_wait) begin
            case (op_phase)
                FETCH: begin
                    nx_alu_smux = 1'b0;
                    nx_alu_wait = 1'b0;
                    fetched     = 2'd1; // unknown bytes go as NOP
                    casez (op[7:0])
                        `CPU_OP_NOP: fetched = 2'd1;
                        8'b1111_????: fetched = 2'd1;
                        8'b11??_1???: begin // prefix with short register r
                            nx_op_zz = op[5:4];
                            nx_dst   = expand_reg(op[2:0], op[5:4]);
                            nx_phase = EXEC;
                        end
                        8'b11??_0111: begin // prefix with full register code
                            nx_op_zz = op[5:4];
                            nx_dst   = op[15:8];
                            nx_phase = EXEC;
                            fetched  = 2'd2;
                        end
                        8'b0???_0???: begin
                            if (op[6:4] >= `CPU_ZZZ_BYTE && op[6:4] <= `CPU_ZZZ_LONG) begin
                                nx_op_zz    = 2'(op[6:4] - `CPU_ZZZ_BYTE);
                                nx_dst      = expand_reg(op[2:0], nx_op_zz);
                                nx_alu_imm  = {24'd0, op[15:8]};
                                nx_alu_op   = ALU_MOVE;
                                nx_alu_smux = 1'b1;
                                nx_regs_we  = zz_size(nx_op_zz);
                                fetched     = 2'd2;
                                if (nx_op_zz != 2'd0) begin
                                    nx_alu_wait = 1'b1; // upper bytes follow
                                    nx_phase    = FILL_IMM;
                                end
                            end
                        end
                        default: fetched = 2'd1;
                    endcase
                end
                EXEC: begin
                    nx_phase = FETCH;
                    fetched  = 2'd1;
                    casez (op[7:0])
                        8'b1000_1???: begin // LD R,r
                            nx_src      = ex.regs_dst;
                            nx_dst      = expand_reg(op[2:0], op_zz);
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b0;
                            nx_regs_we  = zz_size(op_zz);
                        end
                        8'b1001_1???: begin // LD r,R
                            nx_src      = expand_reg(op[2:0], op_zz);
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b0;
                            nx_regs_we  = zz_size(op_zz);
                        end
                        8'b1010_1???: begin // LD r,#3
                            nx_alu_imm  = {29'd0, op[2:0]};
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            nx_regs_we  = zz_size(op_zz);
                        end
                        `CPU_OP_LD_IMM: begin
                            nx_alu_imm  = {24'd0, op[15:8]};
                            nx_alu_op   = ALU_MOVE;
                            nx_alu_smux = 1'b1;
                            nx_regs_we  = zz_size(op_zz);
                            fetched     = 2'd2;
                            if (op_zz != 2'd0) begin
                                nx_alu_wait = 1'b1;
                                nx_phase    = FILL_IMM;
                            end
                        end
                        default: fetched = 2'd1;
                    endcase
                end
                FILL_IMM: begin
                    nx_alu_wait = 1'b0; // releases the held move
                    nx_phase    = FETCH;
                    if (op_zz == 2'd1) begin
                        nx_alu_imm[31:8] = {16'd0, op[7:0]};
                        fetched          = 2'd1;
                    end else begin
                        nx_alu_imm[31:8] = op[23:0];
                        fetched          = 2'd3;
                    end
                end
                default: nx_phase = FETCH;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_phase    <= FETCH;
            op_zz       <= 2'd0;
            ram_wait    <= 1'b0;
            ex.alu_op   <= ALU_NOP;
            ex.alu_wait <= 1'b0;
            ex.regs_we  <= SZ_NONE;
        end else begin
            op_phase    <= nx_phase;
            op_zz       <= nx_op_zz;
            ram_wait    <= fetched != 2'd0;
            ex.alu_op   <= nx_alu_op;
            ex.alu_wait <= nx_alu_wait;
            ex.regs_we  <= nx_regs_we;
        end
    end

    always_ff @(posedge clk) begin
        ex.regs_src <= nx_src;
        ex.regs_dst <= nx_dst;
        ex.alu_imm  <= nx_alu_imm;
        ex.alu_smux <= nx_alu_smux;
    end

    a_wait_in_fill: assert property (@(posedge clk) disable iff (rst)
        ex.alu_wait |-> (op_phase == FILL_IMM));

    // each move reaches the register bank exactly once
    a_move_once: assert property (@(posedge clk) disable iff (rst)
        (ex.alu_op == ALU_MOVE && !ex.alu_wait) |=> (ex.alu_op == ALU_NOP));

endmodule

`default_nettype wire

// File: hdl/reg_exec.sv
// 32-byte register bank, codes E0..FF by their low five bits
// a move writes 1, 2 or 4 bytes from regs_dst upwards, little endian
// source bytes are read before the write, so overlapping moves are safe
`timescale 1ns/1ns
`default_nettype none

module reg_exec import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    exec_if.exec       ex,
    input  logic [2:0] dbg_sel,
    output word_t      dbg_data
);

    byte_t      rbank [32];
    logic       mv_ok;
    logic [4:0] src_idx;
    logic [4:0] dst_idx;
    logic [4:0] dbg_idx;
    logic [3:0] lane_en;
    word_t      src_data;
    word_t      wr_data;

    assign mv_ok   = (ex.alu_op == ALU_MOVE) && !ex.alu_wait;
    assign src_idx = ex.regs_src[4:0];
    assign dst_idx = ex.regs_dst[4:0];
    assign dbg_idx = {dbg_sel, 2'b00}; // E0, E4 .. FC
    assign wr_data = ex.alu_smux ? ex.alu_imm : src_data;

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            src_data[8*i +: 8] = rbank[src_idx + 5'(i)];
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dbg_data[8*i +: 8] = rbank[dbg_idx + 5'(i)];
        end
    end

    always_comb begin
        case (ex.regs_we)
            SZ_BYTE: lane_en = 4'b0001;
            SZ_WORD: lane_en = 4'b0011;
            SZ_LONG: lane_en = 4'b1111;
            default: lane_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                rbank[i] <= '0;
            end
        end else if (mv_ok) begin
            for (int i = 0; i < 4; i++) begin
                if (lane_en[i]) begin
                    rbank[dst_idx + 5'(i)] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // the decoder must never hand over a misaligned destination
    a_word_align: assert property (@(posedge clk) disable iff (rst)
        (mv_ok && ex.regs_we == SZ_WORD) |-> !ex.regs_dst[0]);

    a_long_align: assert property (@(posedge clk) disable iff (rst)
        (mv_ok && ex.regs_we == SZ_LONG) |-> (ex.regs_dst[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
// cpu front end, Wishbone classic instruction port and debug register port
// dbg_sel 0..3 reads E0..EC, 4..7 reads F0..FC
// dbg_data shows a write one cycle after the move is sampled
`timescale 1ns/1ns
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  word_t      wb_dat_i,
    input  logic       wb_ack,
    input  logic [2:0] dbg_sel,
    output logic       wb_cyc,
    output logic       wb_stb,
    output addr_t      wb_adr,
    output logic [3:0] wb_sel,
    output word_t      dbg_data
);

    opwin_t     op;
    logic       op_ok;
    fetch_cnt_t fetched;

    exec_if ex ();

    fetch_queue u_fetch (
        .clk      (clk),
        .rst      (rst),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .fetched  (fetched),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .op       (op),
        .op_ok    (op_ok)
    );

    decode_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .op      (op),
        .op_ok   (op_ok),
        .fetched (fetched),
        .ex      (ex.ctrl)
    );

    reg_exec u_exec (
        .clk      (clk),
        .rst      (rst),
        .ex       (ex.exec),
        .dbg_sel  (dbg_sel),
        .dbg_data (dbg_data)
    );

endmodule

`default_nettype wire

// File: verif/cpu_tb.sv
// directed tests for the cpu front end through its Wishbone port and debug port
// program memory is 256 bytes, every address above it reads as NOP
// registers are checked only after the fetch has run well past the program end
`timescale 1ns/1ns
`default_nettype none
`include "cpu_consts.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int MEM_BYTES       = 256;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 400;
    localparam int CYCLE_LIMIT     = NUM_TESTS * CYCLES_PER_TEST;

    logic       clk      = 1'b0;
    logic       rst      = 1'b1;
    word_t      wb_dat_i = '0;
    logic       wb_ack   = 1'b0;
    logic [2:0] dbg_sel  = 3'd0;
    logic       wb_cyc;
    logic       wb_stb;
    addr_t      wb_adr;
    logic [3:0] wb_sel;
    word_t      dbg_data;

    byte_t      prog_mem [MEM_BYTES];
    byte_t      exp_bank [32];   // expected register bytes, E0 first
    int         prog_len = 0;
    int         err_cnt  = 0;
    int         cycles   = 0;
    logic [1:0] wait_cnt = 2'd0;

    cpu_top DUT (
        .clk      (clk),
        .rst      (rst),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .dbg_sel  (dbg_sel),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_sel   (wb_sel),
        .dbg_data (dbg_data)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic word_t mem_word(input addr_t a);
        word_t w;
        int    k;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            k = int'(a) + i;
            if (k < MEM_BYTES) begin
                w[8*i +: 8] = prog_mem[k];
            end
        end
        return w;
    endfunction

    // memory answers after 0 to 3 random wait states
    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wait_cnt <= 2'($urandom % 4);
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_cnt == 2'd0) begin
                check_sel("wb_sel", wb_sel, 4'hf); // all byte lanes on every read
                wb_ack   <= 1'b1;
                wb_dat_i <= mem_word(wb_adr);
                wait_cnt <= 2'($urandom % 4);
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end else begin
            wb_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, a program never finished", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_sel(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // expected register image
    task automatic set_bytes(input int idx, input int n, input word_t v);
        for (int i = 0; i < n; i++) begin
            exp_bank[idx + i] = v[8*i +: 8];
        end
    endtask

    function automatic word_t get_bytes(input int idx, input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = exp_bank[idx + i];
        end
        return v;
    endfunction

    function automatic int reg_idx(input int sz, input int r);
        if (sz == 1) begin
            return (r / 2) * 4 + 1 - (r % 2); // byte r is lane 1-(r mod 2) of reg r/2
        end
        return r * 4;
    endfunction

    function automatic logic [1:0] sz_zz(input int sz);
        case (sz)
            1:       return 2'd0;
            2:       return 2'd1;
            default: return 2'd2;
        endcase
    endfunction

    task automatic set_code(input byte_t code, input int sz, input word_t v);
        set_bytes(int'(code) - int'(`CPU_REG_BASE), sz, v);
    endtask

    // program builder
    task automatic clear_prog();
        for (int i = 0; i < MEM_BYTES; i++) begin
            prog_mem[i] = 8'h00;
        end
        for (int i = 0; i < 32; i++) begin
            exp_bank[i] = 8'h00;
        end
        prog_len = 0;
    endtask

    task automatic emit(input byte_t b);
        prog_mem[prog_len] = b;
        prog_len++;
    endtask

    task automatic emit_imm(input word_t v, input int n);
        for (int i = 0; i < n; i++) begin
            emit(v[8*i +: 8]);
        end
    endtask

    task automatic ld_imm(input int sz, input int r, input word_t v);
        logic [2:0] zzz;
        zzz = 3'd2 + {1'b0, sz_zz(sz)};
        emit({1'b0, zzz, 1'b0, 3'(r)});
        emit_imm(v, sz);
        set_bytes(reg_idx(sz, r), sz, v);
    endtask

    task automatic prefix(input int sz, input int r);
        emit({2'b11, sz_zz(sz), 1'b1, 3'(r)});
    endtask

    task automatic ext_prefix(input int sz, input byte_t code);
        emit({2'b11, sz_zz(sz), 4'b0111});
        emit(code);
    endtask

    task automatic ld_rr(input int sz, input int dst, input int src);
        prefix(sz, src);
        emit({5'b10001, 3'(dst)}); // LD R,r
        set_bytes(reg_idx(sz, dst), sz, get_bytes(reg_idx(sz, src), sz));
    endtask

    task automatic ld_r_big(input int sz, input int dst, input int src);
        prefix(sz, dst);
        emit({5'b10011, 3'(src)}); // LD r,R
        set_bytes(reg_idx(sz, dst), sz, get_bytes(reg_idx(sz, src), sz));
    endtask

    task automatic ld_imm3(input int sz, input int r, input int n);
        prefix(sz, r);
        emit({5'b10101, 3'(n)});
        set_bytes(reg_idx(sz, r), sz, word_t'(n));
    endtask

    task automatic pfx_imm(input int sz, input int r, input word_t v);
        prefix(sz, r);
        emit(`CPU_OP_LD_IMM);
        emit_imm(v, sz);
        set_bytes(reg_idx(sz, r), sz, v);
    endtask

    // DUT control
    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_program();
        int limit;
        limit = ((prog_len + 3) / 4) * 4 + 16; // four words of NOPs past the end
        do begin
            @(negedge clk);
        end while (!(wb_cyc && wb_ack && wb_adr >= addr_t'(limit)));
    endtask

    task automatic check_regs();
        for (int s = 0; s < 8; s++) begin
            @(posedge clk);
            dbg_sel <= 3'(s);
            @(negedge clk);
            check_word($sformatf("dbg_data[%0d]", s), dbg_data, get_bytes(4 * s, 4));
        end
    endtask

    task automatic run_and_check();
        apply_reset();
        run_program();
        check_regs();
    endtask

    // tests
    task automatic test_reset();
        clear_prog();
        apply_reset();
        do begin
            @(negedge clk);
        end while (!wb_cyc);
        check_addr("wb_adr", wb_adr, `CPU_RESET_PC);
        run_program();
        check_regs();
    endtask

    task automatic test_ld_imm();
        clear_prog();
        ld_imm(1, 1, 32'h5a);
        ld_imm(1, 0, 32'h3c);
        ld_imm(1, 7, 32'h99);
        ld_imm(2, 2, 32'h1234);
        ld_imm(4, 5, 32'h1234_5678);
        ld_imm(1, 6, 32'hee);
        ld_imm(2, 5, 32'habcd); // upper half of reg 5 stays
        run_and_check();
    endtask

    task automatic test_ld_reg();
        clear_prog();
        ld_imm(4, 1, 32'h1122_3344);
        ld_imm(4, 6, 32'ha5a5_5a5a);
        ld_rr(4, 4, 1);
        ld_r_big(4, 7, 6);
        ld_rr(2, 2, 1);
        ld_r_big(2, 6, 4);
        ld_imm(1, 0, 32'hb7);
        ld_rr(1, 5, 0);
        ld_r_big(1, 3, 0);
        run_and_check();
    endtask

    task automatic test_ld_imm3();
        clear_prog();
        ld_imm(4, 1, 32'hffff_ffff);
        ld_imm(4, 3, 32'hffff_ffff);
        ld_imm(4, 6, 32'hffff_ffff);
        ld_imm3(1, 2, 5);
        ld_imm3(2, 3, 7);
        ld_imm3(4, 6, 3);
        run_and_check();
    endtask

    task automatic test_pfx_imm();
        clear_prog();
        pfx_imm(1, 4, 32'h6d);
        pfx_imm(2, 0, 32'h4321);
        pfx_imm(4, 7, 32'hdead_beef);
        pfx_imm(1, 0, 32'h9c);
        run_and_check();
    endtask

    task automatic test_ext_and_skip();
        clear_prog();
        emit(8'h08);
        ext_prefix(4, 8'hf0);
        emit(`CPU_OP_LD_IMM);
        emit_imm(32'h0bad_f00d, 4);
        set_code(8'hf0, 4, 32'h0bad_f00d);
        emit(8'h17);
        ext_prefix(2, 8'hea);  // upper half of reg 2
        emit(`CPU_OP_LD_IMM);
        emit_imm(32'h1234, 2);
        set_code(8'hea, 2, 32'h1234);
        emit(8'h55);
        emit(8'h80);
        ext_prefix(1, 8'hfd);
        emit({5'b10101, 3'd6});
        set_code(8'hfd, 1, 32'd6);
        emit(8'hb4);
        ext_prefix(4, 8'hf0);
        emit({5'b10001, 3'd1}); // reg 1 takes the F0 register
        set_bytes(reg_idx(4, 1), 4, get_bytes(int'(8'hf0) - int'(`CPU_REG_BASE), 4));
        emit(8'hf3);
        run_and_check();
    endtask

    initial begin
        void'($urandom(32'he8ef));
        test_reset();
        test_ld_imm();
        test_ld_reg();
        test_ld_imm3();
        test_pfx_imm();
        test_ext_and_skip();
        $display("tests done, %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/exec_if.sv
hdl/fetch_queue.sv
hdl/decode_ctrl.sv
hdl/reg_exec.sv
hdl/cpu_top.sv
verif/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the cpu front end testbench with Verilator, runs it and checks sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpu_tb -f project.f -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "STATUS: PASS" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
